//--- keypad.f
rtl/keypad_pkg.sv
rtl/column_scanner.sv
rtl/row_debouncer.sv
rtl/button_decoder.sv
rtl/keypad_wb_regs.sv
rtl/keypad_top.sv
testbench/keypad_props.sv
testbench/keypad_tb.sv

//--- Makefile
# Verilator build and run for the keypad controller testbench

VERILATOR ?= verilator
TOP       ?= keypad_tb
FILELIST  ?= keypad.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the simulator's own exit status is ignored, the log decides
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/keypad_tb.sv
`timescale 1ns/1ps

module keypad_tb;
    import keypad_pkg::*;

    localparam int ACK_TIMEOUT = 16;
    localparam int POLL_LIMIT = 200;     // STATUS reads before giving up
    localparam int SETTLE_TIMEOUT = 400;
    localparam int VALID_TIMEOUT = 600;
    localparam int IDLE_POLLS = 100;

    // {alpha, row bit, column bit, expected code}
    localparam logic [9:0] KEY_TABLE [32] = '{
        {1'b0, 2'd3, 2'd3, 5'd12}, {1'b0, 2'd2, 2'd3, 5'd13},
        {1'b0, 2'd1, 2'd3, 5'd14}, {1'b0, 2'd0, 2'd3, 5'd15},
        {1'b0, 2'd3, 2'd2, 5'd9},  {1'b0, 2'd2, 2'd2, 5'd6},
        {1'b0, 2'd1, 2'd2, 5'd3},  {1'b0, 2'd0, 2'd2, 5'd11},
        {1'b0, 2'd3, 2'd1, 5'd8},  {1'b0, 2'd2, 2'd1, 5'd5},
        {1'b0, 2'd1, 2'd1, 5'd2},  {1'b0, 2'd0, 2'd1, 5'd10},
        {1'b0, 2'd3, 2'd0, 5'd7},  {1'b0, 2'd2, 2'd0, 5'd4},
        {1'b0, 2'd1, 2'd0, 5'd1},  {1'b0, 2'd0, 2'd0, 5'd0},
        {1'b1, 2'd3, 2'd3, 5'd19}, {1'b1, 2'd2, 2'd3, 5'd23},
        {1'b1, 2'd1, 2'd3, 5'd27}, {1'b1, 2'd0, 2'd3, 5'd31},
        {1'b1, 2'd3, 2'd2, 5'd18}, {1'b1, 2'd2, 2'd2, 5'd22},
        {1'b1, 2'd1, 2'd2, 5'd26}, {1'b1, 2'd0, 2'd2, 5'd30},
        {1'b1, 2'd3, 2'd1, 5'd17}, {1'b1, 2'd2, 2'd1, 5'd21},
        {1'b1, 2'd1, 2'd1, 5'd25}, {1'b1, 2'd0, 2'd1, 5'd10},
        {1'b1, 2'd3, 2'd0, 5'd16}, {1'b1, 2'd2, 2'd0, 5'd20},
        {1'b1, 2'd1, 2'd0, 5'd24}, {1'b1, 2'd0, 2'd0, 5'd29}
    };

    logic                 clk;
    logic                 rst;
    logic                 wb_cyc;
    logic                 wb_stb;
    logic                 wb_we;
    logic [WB_ADDR_W-1:0] wb_adr;
    logic [WB_DATA_W-1:0] wb_dat_i;
    logic [WB_DATA_W-1:0] wb_dat_o;
    logic                 wb_ack;
    logic [NUM_COLS-1:0]  column;
    logic [NUM_ROWS-1:0]  row;

    logic       pressed;
    logic [1:0] press_row;
    logic [1:0] press_col;
    logic [7:0] rdata;
    logic [9:0] entry;
    int         errors;
    int         tests_ok;
    int         tests_bad;
    int         start;
    int         hold;
    string      test_name;

    keypad_top dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack   (wb_ack),
        .column   (column),
        .row      (row)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // a pressed switch ties its row to its column drive
    initial begin
        row = '0;
        forever begin
            @(negedge clk);
            row = (pressed && column[press_col]) ? (4'b0001 << press_row) : 4'b0000;
        end
    end

    task automatic abort_on_timeout(input string what);
        $display("timeout at %0t ns while waiting for %s", $time, what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got == exp) else begin
            $display("** Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic wb_write(input logic [WB_ADDR_W-1:0] adr, input logic [7:0] data);
        int waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr;
        wb_dat_i = data;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) abort_on_timeout("ack on a write");
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input logic [WB_ADDR_W-1:0] adr, output logic [7:0] data);
        int waited = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack && waited < ACK_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_ack) abort_on_timeout("ack on a read");
        data = wb_dat_o;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic press_key(input logic [1:0] r, input logic [1:0] c);
        press_row = r;
        press_col = c;
        pressed = 1'b1;
    endtask

    // let go and wait until the debounced rows are quiet again
    task automatic release_key();
        int waited = 0;
        pressed = 1'b0;
        while (dut.row_db != '0 && waited < SETTLE_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (dut.row_db != '0) abort_on_timeout("the debounced rows to clear");
    endtask

    task automatic wait_status_count(input logic [2:0] n);
        logic [7:0] status;
        int         polls = 0;
        wb_read(ADDR_STATUS, status);
        while (status[4:2] != n && polls < POLL_LIMIT) begin
            wb_read(ADDR_STATUS, status);
            polls++;
        end
        if (status[4:2] != n) abort_on_timeout("the FIFO count to rise");
    endtask

    task automatic wait_key_valid();
        int waited = 0;
        while (!dut.key_valid && waited < VALID_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!dut.key_valid) abort_on_timeout("a key report");
    endtask

    initial begin
        void'($urandom(32'h9f1b_a421));
        errors = 0;
        tests_ok = 0;
        tests_bad = 0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_i = '0;
        pressed = 1'b0;
        press_row = 2'd0;
        press_col = 2'd0;
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start = errors;
        check_value("column", {4'b0000, column}, 8'h01);
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'd0);
        wb_read(ADDR_CTRL, rdata);
        check_value("ctrl", rdata, 8'd0);
        press_key(2'd0, 2'd0); // column 0 is driven while idle
        for (int i = 0; i < IDLE_POLLS; i++) begin
            wb_read(ADDR_STATUS, rdata);
            check_value("status", rdata, 8'd0);
        end
        release_key();
        end_test("reset and scan off", start);

        for (int i = 0; i < 32; i++) begin
            entry = KEY_TABLE[i];
            start = errors;
            test_name = $sformatf("%s key row %0d col %0d", entry[9] ? "alpha" : "numeric",
                entry[8:7], entry[6:5]);
            wb_write(ADDR_CTRL, {6'b0, 1'b1, entry[9]});
            press_key(entry[8:7], entry[6:5]);
            wait_status_count(3'd1);
            wb_read(ADDR_DATA, rdata);
            check_value("key code", rdata, {3'b000, entry[4:0]});
            hold = $urandom_range(0, 63);
            repeat (hold) @(negedge clk);
            release_key();
            end_test(test_name, start);
        end

        start = errors;
        wb_write(ADDR_CTRL, 8'h02);
        press_key(2'd2, 2'd1); // numeric 5
        wait_status_count(3'd1);
        hold = $urandom_range(200, 700);
        repeat (hold) @(negedge clk);
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'h05); // count 1, not empty
        release_key();
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'h05);
        wb_read(ADDR_DATA, rdata);
        check_value("key code", rdata, 8'd5);
        end_test("long hold gives one code", start);

        start = errors;
        for (int k = 0; k < 5; k++) begin
            press_key(KEY_TABLE[k][8:7], KEY_TABLE[k][6:5]);
            if (k < 4) begin
                wait_status_count(3'(k + 1));
            end else begin
                wait_key_valid(); // the fifth code is dropped
            end
            release_key();
        end
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'h13); // count 4, overflow, not empty
        for (int k = 0; k < 4; k++) begin
            wb_read(ADDR_DATA, rdata);
            check_value("key code", rdata, {3'b000, KEY_TABLE[k][4:0]});
        end
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'h00);
        end_test("overflow", start);

        start = errors;
        wb_read(ADDR_DATA, rdata);
        check_value("key code", rdata, 8'd0);
        wb_read(ADDR_STATUS, rdata);
        check_value("status", rdata, 8'h00);
        end_test("empty data read", start);

        $display("%0d tests ok, %0d tests failed, %0d errors, %0d assertion failures",
            tests_ok, tests_bad, errors, dut.u_props.failures);
        if (errors == 0 && dut.u_props.failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- testbench/keypad_props.sv
`timescale 1ns/1ps

module keypad_props (
    input logic                            clk,
    input logic                            rst,
    input logic                            wb_ack,
    input logic                            key_valid,
    input logic [keypad_pkg::NUM_COLS-1:0] column,
    input logic                            tick,
    input logic                            scan_enable
);
    int unsigned failures = 0; // read by the testbench at the end

    ack_one_cycle: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack high for more than one cycle");
            failures++;
        end

    valid_single: assert property (@(posedge clk) disable iff (rst) key_valid |=> !key_valid)
        else begin
            $error("key_valid high on two cycles in a row");
            failures++;
        end

    column_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(column))
        else begin
            $error("column is not one-hot");
            failures++;
        end

    // tick is registered, so allow the cycle right after enable drops
    tick_idle: assert property (@(posedge clk) disable iff (rst)
        (!scan_enable && !$past(scan_enable)) |-> !tick)
        else begin
            $error("tick active while scanning is off");
            failures++;
        end

endmodule

bind keypad_top keypad_props u_props (
    .clk         (clk),
    .rst         (rst),
    .wb_ack      (wb_ack),
    .key_valid   (key_valid),
    .column      (column),
    .tick        (tick),
    .scan_enable (scan_enable)
);

//--- rtl/keypad_top.sv
`timescale 1ns/1ps

module keypad_top (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [keypad_pkg::WB_ADDR_W-1:0]   wb_adr,
    input  logic [keypad_pkg::WB_DATA_W-1:0]   wb_dat_i,
    output logic [keypad_pkg::WB_DATA_W-1:0]   wb_dat_o,
    output logic                               wb_ack,
    output logic [keypad_pkg::NUM_COLS-1:0]    column,
    input  logic [keypad_pkg::NUM_ROWS-1:0]    row
);
    import keypad_pkg::*;

    logic                scan_enable;
    logic                alpha;
    logic                tick;
    logic [NUM_ROWS-1:0] row_db; // debounced rows
    key_code_t           key_code;
    logic                key_valid;

    column_scanner u_scanner (
        .clk     (clk),
        .rst     (rst),
        .enable  (scan_enable),
        .row_raw (row),
        .column  (column),
        .tick    (tick)
    );

    for (genvar i = 0; i < NUM_ROWS; i++) begin : g_row
        row_debouncer u_debouncer (
            .clk     (clk),
            .rst     (rst),
            .tick    (tick),
            .row_in  (row[i]),
            .row_out (row_db[i])
        );
    end

    button_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .alpha     (alpha),
        .pulse     (tick),
        .row       (row_db),
        .column    (column),
        .button    (key_code),
        .key_valid (key_valid)
    );

    keypad_wb_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack      (wb_ack),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .alpha       (alpha),
        .scan_enable (scan_enable)
    );

endmodule

//--- rtl/keypad_wb_regs.sv
`timescale 1ns/1ps

module keypad_wb_regs (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  logic [keypad_pkg::WB_ADDR_W-1:0]   wb_adr,
    input  logic [keypad_pkg::WB_DATA_W-1:0]   wb_dat_i,
    output logic [keypad_pkg::WB_DATA_W-1:0]   wb_dat_o,
    output logic                               wb_ack,
    input  keypad_pkg::key_code_t              key_code,
    input  logic                               key_valid,
    output logic                               alpha,
    output logic                               scan_enable
);
    import keypad_pkg::*;

    logic [1:0]            ctrl;
    logic                  overflow;
    key_code_t             fifo_mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] rd_ptr, wr_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  req, rd_req, wr_req;
    logic                  fifo_empty, fifo_full;
    logic                  do_push, do_pop;

    assign req = wb_cyc && wb_stb && !wb_ack; // one ack per request
    assign rd_req = req && !wb_we;
    assign wr_req = req && wb_we;

    assign fifo_empty = (count == '0);
    assign fifo_full = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign do_push = key_valid && !fifo_full;
    assign do_pop = rd_req && (wb_adr == ADDR_DATA) && !fifo_empty;

    assign alpha = ctrl[0];
    assign scan_enable = ctrl[1];

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
            ctrl <= '0;
            overflow <= 1'b0;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            wb_ack <= req;
            if (wr_req && wb_adr == ADDR_CTRL) begin
                ctrl <= wb_dat_i[1:0];
            end

            // a new drop wins over a status read in the same cycle
            if (key_valid && fifo_full) begin
                overflow <= 1'b1;
            end else if (rd_req && wb_adr == ADDR_STATUS) begin
                overflow <= 1'b0;
            end

            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            fifo_mem[wr_ptr] <= key_code;
        end
        if (rd_req) begin
            case (wb_adr)
                ADDR_STATUS: wb_dat_o <= WB_DATA_W'({count, overflow, !fifo_empty});
                ADDR_DATA:   wb_dat_o <= fifo_empty ? '0 : WB_DATA_W'(fifo_mem[rd_ptr]);
                ADDR_CTRL:   wb_dat_o <= WB_DATA_W'(ctrl);
                default:     wb_dat_o <= '0;
            endcase
        end
    end

endmodule

//--- rtl/button_decoder.sv
`timescale 1ns/1ps

module button_decoder (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              alpha,
    input  logic                              pulse,
    input  logic [keypad_pkg::NUM_ROWS-1:0]   row,    // debounced rows
    input  logic [keypad_pkg::NUM_COLS-1:0]   column,
    output keypad_pkg::key_code_t             button,
    output logic                              key_valid
);
    import keypad_pkg::*;

    logic      d1, d2, q2;       // any-row edge detector
    logic      push, push_n;     // press seen since last pulse
    logic [4:0] sticky, sticky_n; // press history with the newest in msb
    logic      rising;
    key_code_t button_n;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            d2 <= 1'b0;
            q2 <= 1'b0;
            push <= 1'b0;
            sticky <= '0;
            button <= '0;
            key_valid <= 1'b0;
        end else begin
            d2 <= d1;
            q2 <= d2;
            push <= push_n;
            sticky <= sticky_n;
            button <= button_n;
            key_valid <= rising; // lines up with the registered code
        end
    end

    always_comb begin
        d1 = |row;

        if (d2 && !q2) begin
            push_n = 1'b1;
        end else if (pulse) begin
            push_n = 1'b0;
        end else begin
            push_n = push;
        end

        sticky_n = pulse ? {push, sticky[4:1]} : sticky;

        // only a press after a quiet history counts as new
        rising = pulse && (sticky_n == 5'b10000);
    end

    always_comb begin
        button_n = button;
        if (rising) begin
            if (alpha) begin
                case (column)
                    4'b1000: case (row)
                        4'b1000: button_n = 5'd19;
                        4'b0100: button_n = 5'd23;
                        4'b0010: button_n = 5'd27;
                        4'b0001: button_n = 5'd31;
                        default: button_n = button;
                    endcase
                    4'b0100: case (row)
                        4'b1000: button_n = 5'd18;
                        4'b0100: button_n = 5'd22;
                        4'b0010: button_n = 5'd26;
                        4'b0001: button_n = 5'd30;
                        default: button_n = button;
                    endcase
                    4'b0010: case (row)
                        4'b1000: button_n = 5'd17;
                        4'b0100: button_n = 5'd21;
                        4'b0010: button_n = 5'd25;
                        4'b0001: button_n = 5'd10;
                        default: button_n = button;
                    endcase
                    4'b0001: case (row)
                        4'b1000: button_n = 5'd16;
                        4'b0100: button_n = 5'd20;
                        4'b0010: button_n = 5'd24;
                        4'b0001: button_n = 5'd29;
                        default: button_n = button;
                    endcase
                    default: button_n = button;
                endcase
            end else begin
                case (column)
                    4'b1000: case (row)
                        4'b1000: button_n = 5'd12;
                        4'b0100: button_n = 5'd13;
                        4'b0010: button_n = 5'd14;
                        4'b0001: button_n = 5'd15;
                        default: button_n = button;
                    endcase
                    4'b0100: case (row)
                        4'b1000: button_n = 5'd9;
                        4'b0100: button_n = 5'd6;
                        4'b0010: button_n = 5'd3;
                        4'b0001: button_n = 5'd11;
                        default: button_n = button;
                    endcase
                    4'b0010: case (row)
                        4'b1000: button_n = 5'd8;
                        4'b0100: button_n = 5'd5;
                        4'b0010: button_n = 5'd2;
                        4'b0001: button_n = 5'd10;
                        default: button_n = button;
                    endcase
                    4'b0001: case (row)
                        4'b1000: button_n = 5'd7;
                        4'b0100: button_n = 5'd4;
                        4'b0010: button_n = 5'd1;
                        4'b0001: button_n = 5'd0;
                        default: button_n = button;
                    endcase
                    default: button_n = button;
                endcase
            end
        end
    end

endmodule

//--- rtl/row_debouncer.sv
`timescale 1ns/1ps

module row_debouncer (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic row_in,
    output logic row_out
);
    import keypad_pkg::*;

    logic                 sync_1;
    logic                 sync_2;
    logic [DEB_CNT_W-1:0] stable_cnt; // ticks the input has differed from row_out

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            sync_1 <= 1'b0;
            sync_2 <= 1'b0;
            stable_cnt <= '0;
            row_out <= 1'b0;
        end else begin
            sync_1 <= row_in;
            sync_2 <= sync_1;
            if (tick) begin
                if (sync_2 == row_out) begin
                    stable_cnt <= '0; // no change or a glitch restarts the count
                end else if (stable_cnt == DEB_CNT_W'(DEBOUNCE_TICKS - 1)) begin
                    row_out <= sync_2;
                    stable_cnt <= '0;
                end else begin
                    stable_cnt <= stable_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- rtl/column_scanner.sv
`timescale 1ns/1ps

module column_scanner (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              enable,
    input  logic [keypad_pkg::NUM_ROWS-1:0]   row_raw,
    output logic [keypad_pkg::NUM_COLS-1:0]   column,
    output logic                              tick
);
    import keypad_pkg::*;

    logic [SCAN_CNT_W-1:0] div_cnt;
    logic                  div_wrap;

    assign div_wrap = (div_cnt == SCAN_CNT_W'(SCAN_DIV - 1));

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            tick <= 1'b0;
            column <= NUM_COLS'(1);
        end else if (!enable) begin
            // park on the first column while idle
            div_cnt <= '0;
            tick <= 1'b0;
            column <= NUM_COLS'(1);
        end else begin
            tick <= div_wrap;
            if (div_wrap) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end

            // stay on this column while a key in it is down
            if (tick && !(|row_raw)) begin
                column <= {column[NUM_COLS-2:0], column[NUM_COLS-1]};
            end
        end
    end

endmodule

//--- rtl/keypad_pkg.sv
package keypad_pkg;

    typedef logic [4:0] key_code_t;

    // keypad matrix size
    localparam int NUM_ROWS = 4;
    localparam int NUM_COLS = 4;

    // scan and debounce timing kept short for simulation
    localparam int SCAN_DIV = 16;
    localparam int SCAN_CNT_W = $clog2(SCAN_DIV);
    localparam int DEBOUNCE_TICKS = 3;
    localparam int DEB_CNT_W = $clog2(DEBOUNCE_TICKS + 1);

    // key queue
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

    // wishbone port
    localparam int WB_ADDR_W = 2;
    localparam int WB_DATA_W = 8;

    localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 2'd0;
    localparam logic [WB_ADDR_W-1:0] ADDR_DATA = 2'd1;
    localparam logic [WB_ADDR_W-1:0] ADDR_CTRL = 2'd2;

endpackage
